//--- hw/qspi_mem_pkg.sv
// Address map assumes one 16 MiB flash and two 8 MiB RAMs behind a 25-bit byte address
package qspi_mem_pkg;

    // Bit 24 clear is flash, otherwise bit 23 picks RAM A or RAM B
    typedef logic [24:0] mem_addr_t;

    // Fetch halfword address, byte address bits 23 to 1
    typedef logic [22:0] instr_addr_t;

    // Index of the last byte: 0, 1 or 3
    typedef logic [1:0] xfer_len_t;

    // Port request: 3 none, 0 byte, 1 half, 2 word
    typedef logic [1:0] size_code_t;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  nibble_t;

    // Device driven by the shared bus
    typedef logic [1:0] dev_sel_t;
    localparam dev_sel_t DEV_NONE  = 2'd0;
    localparam dev_sel_t DEV_FLASH = 2'd1;
    localparam dev_sel_t DEV_RAM_A = 2'd2;
    localparam dev_sel_t DEV_RAM_B = 2'd3;

    typedef enum logic [2:0] {IDLE, CMD, ADDR, DUMMY, DATA} qspi_state_t;

    localparam byte_t CMD_READ  = 8'h0B;
    localparam byte_t CMD_WRITE = 8'h02;

endpackage

//--- hw/qspi_bus_if.sv
// One transfer at a time; the requester must pulse stop to end every transfer
`timescale 1ns/1ps

interface qspi_bus_if;

    // Requester side
    qspi_mem_pkg::mem_addr_t addr;
    qspi_mem_pkg::byte_t     wdata;
    logic                    start_read;
    logic                    start_write;
    logic                    stall;
    logic                    stop;

    // Engine side
    qspi_mem_pkg::byte_t     rdata;
    logic                    data_req;
    logic                    data_ready;
    logic                    busy;

    modport requester (
        output addr, wdata, start_read, start_write, stall, stop,
        input  rdata, data_req, data_ready, busy
    );

    modport engine (
        input  addr, wdata, start_read, start_write, stall, stop,
        output rdata, data_req, data_ready, busy
    );

endinterface

//--- hw/qspi_controller.sv
// SPI clock is clk/2 with no divider; DUMMY_CYCLES from 0 to 16; stop ends every stream
`timescale 1ns/1ps

module qspi_controller #(
    parameter int DUMMY_CYCLES = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    qspi_bus_if.engine            bus,
    input  qspi_mem_pkg::nibble_t spi_data_in,
    output qspi_mem_pkg::nibble_t spi_data_out,
    output qspi_mem_pkg::nibble_t spi_data_oe,
    output logic                  spi_clk_out,
    output logic                  spi_flash_select,
    output logic                  spi_ram_a_select,
    output logic                  spi_ram_b_select
);

    qspi_mem_pkg::qspi_state_t state;
    qspi_mem_pkg::dev_sel_t    dev;
    qspi_mem_pkg::dev_sel_t    dev_decode;
    qspi_mem_pkg::byte_t       rd_shift;
    logic [31:0]               shift_reg;
    logic [3:0]                nib_cnt;
    logic                      is_write;
    logic                      nib_lo;
    logic                      fall_tick;
    logic                      rise_tick;

    // SPI clock edges that happen at the end of this cycle
    assign fall_tick = state != qspi_mem_pkg::IDLE && !bus.stall && spi_clk_out;
    assign rise_tick = state != qspi_mem_pkg::IDLE && !bus.stall && !spi_clk_out;

    always_comb begin
        if (!bus.addr[24]) begin
            dev_decode = qspi_mem_pkg::DEV_FLASH;
        end else if (bus.addr[23]) begin
            dev_decode = qspi_mem_pkg::DEV_RAM_B;
        end else begin
            dev_decode = qspi_mem_pkg::DEV_RAM_A;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= qspi_mem_pkg::IDLE;
            dev         <= qspi_mem_pkg::DEV_NONE;
            spi_data_oe <= '0;
            spi_clk_out <= 1'b0;
            nib_cnt     <= '0;
            is_write    <= 1'b0;
            nib_lo      <= 1'b0;
        end else if (bus.stop) begin
            state       <= qspi_mem_pkg::IDLE;
            dev         <= qspi_mem_pkg::DEV_NONE;
            spi_data_oe <= '0;
            spi_clk_out <= 1'b0;
        end else if (state == qspi_mem_pkg::IDLE) begin
            if (bus.start_read || bus.start_write) begin
                state       <= qspi_mem_pkg::CMD;
                dev         <= dev_decode;
                is_write    <= bus.start_write;
                spi_data_oe <= 4'hf;
                nib_cnt     <= '0;
            end
        end else if (!bus.stall) begin
            spi_clk_out <= !spi_clk_out;
            if (spi_clk_out) begin
                // Falling edge, next nibble goes out
                nib_cnt <= nib_cnt + 4'd1;
                case (state)
                    qspi_mem_pkg::CMD: begin
                        if (nib_cnt == 4'd1) begin
                            state   <= qspi_mem_pkg::ADDR;
                            nib_cnt <= '0;
                        end
                    end
                    qspi_mem_pkg::ADDR: begin
                        if (nib_cnt == 4'd5) begin
                            nib_cnt <= '0;
                            nib_lo  <= 1'b0;
                            if (is_write) begin
                                state <= qspi_mem_pkg::DATA;
                            end else begin
                                // Release lanes for the device turnaround
                                spi_data_oe <= '0;
                                if (DUMMY_CYCLES == 0) begin
                                    state <= qspi_mem_pkg::DATA;
                                end else begin
                                    state <= qspi_mem_pkg::DUMMY;
                                end
                            end
                        end
                    end
                    qspi_mem_pkg::DUMMY: begin
                        if (nib_cnt == 4'(DUMMY_CYCLES - 1)) begin
                            state   <= qspi_mem_pkg::DATA;
                            nib_cnt <= '0;
                        end
                    end
                    qspi_mem_pkg::DATA: begin
                        if (is_write) begin
                            nib_lo <= !nib_lo;
                        end
                    end
                    default: begin
                        state <= qspi_mem_pkg::IDLE;
                    end
                endcase
            end else if (state == qspi_mem_pkg::DATA && !is_write) begin
                // Read nibbles are captured on the rising edge
                nib_lo <= !nib_lo;
            end
        end
    end

    // Command and address, then write bytes, leave from the top nibble
    always_ff @(posedge clk) begin
        if (state == qspi_mem_pkg::IDLE) begin
            shift_reg <= {bus.start_write ? qspi_mem_pkg::CMD_WRITE : qspi_mem_pkg::CMD_READ,
                          bus.addr[23:0]};
        end else if (fall_tick) begin
            if ((state == qspi_mem_pkg::ADDR && nib_cnt == 4'd5) ||
                (state == qspi_mem_pkg::DATA && nib_lo)) begin
                shift_reg[31:24] <= bus.wdata;
            end else begin
                shift_reg <= shift_reg << 4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rise_tick) begin
            rd_shift <= {rd_shift[3:0], spi_data_in};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.data_req   <= 1'b0;
            bus.data_ready <= 1'b0;
        end else if (bus.stop) begin
            bus.data_req   <= 1'b0;
            bus.data_ready <= 1'b0;
        end else begin
            // Write byte consumed once its low nibble is on the lanes
            bus.data_req   <= fall_tick && state == qspi_mem_pkg::DATA && is_write && !nib_lo;
            bus.data_ready <= rise_tick && state == qspi_mem_pkg::DATA && !is_write && nib_lo;
        end
    end

    assign bus.rdata        = rd_shift;
    assign bus.busy         = state != qspi_mem_pkg::IDLE;
    assign spi_data_out     = shift_reg[31:28];
    assign spi_flash_select = dev != qspi_mem_pkg::DEV_FLASH;
    assign spi_ram_a_select = dev != qspi_mem_pkg::DEV_RAM_A;
    assign spi_ram_b_select = dev != qspi_mem_pkg::DEV_RAM_B;

    // No device stays selected once the engine is idle
    a_one_select: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({!spi_flash_select, !spi_ram_a_select, !spi_ram_b_select}) &&
        (bus.busy || (spi_flash_select && spi_ram_a_select && spi_ram_b_select)));

    // Write bytes are only requested while the lanes are driven
    a_no_req_on_read: assert property (@(posedge clk) disable iff (!rstn)
        bus.data_req |-> spi_data_oe == 4'hf);

    a_single_start: assert property (@(posedge clk) disable iff (!rstn)
        !(bus.start_read && bus.start_write));

endmodule

//--- hw/qspi_mem_ctrl.sv
// Data port beats fetch; data request levels must be held until data_ready
`timescale 1ns/1ps

module qspi_mem_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    qspi_bus_if.requester             bus,
    input  qspi_mem_pkg::instr_addr_t instr_addr,
    input  logic                      instr_fetch_restart,
    input  logic                      instr_fetch_stall,
    output logic                      instr_fetch_started,
    output logic                      instr_fetch_stopped,
    output qspi_mem_pkg::half_t       instr_data,
    output logic                      instr_ready,
    input  qspi_mem_pkg::mem_addr_t   data_addr,
    input  qspi_mem_pkg::size_code_t  data_write_n,
    input  qspi_mem_pkg::size_code_t  data_read_n,
    input  qspi_mem_pkg::word_t       data_to_write,
    output logic                      data_ready,
    output qspi_mem_pkg::word_t       data_from_read
);

    qspi_mem_pkg::size_code_t data_txn_n;
    qspi_mem_pkg::xfer_len_t  data_txn_len;
    qspi_mem_pkg::xfer_len_t  txn_len;
    qspi_mem_pkg::xfer_len_t  byte_idx;
    qspi_mem_pkg::word_t      rd_buf;
    logic                     start_instr;
    logic                     start_read;
    logic                     start_write;
    logic                     stop_txn;
    logic                     instr_active;
    logic                     is_instr;
    logic                     write_done;

    // Size code to last byte index: 0, 1 or 3
    assign data_txn_n   = data_write_n & data_read_n;
    assign data_txn_len = {data_txn_n[1], data_txn_n[1] | data_txn_n[0]};

    always_comb begin
        start_instr = 1'b0;
        start_read  = 1'b0;
        start_write = 1'b0;
        stop_txn    = 1'b0;
        if (bus.busy) begin
            if (instr_active) begin
                if (instr_fetch_restart && !instr_fetch_started) begin
                    stop_txn = 1'b1;
                end else if (bus.data_ready && byte_idx == 2'd1 && data_txn_n != 2'b11) begin
                    // Halfword boundary with a data access waiting
                    stop_txn = 1'b1;
                end
            end else if (write_done || (bus.data_ready && byte_idx == data_txn_len)) begin
                // A write ends once its last low nibble has been clocked out
                stop_txn = 1'b1;
            end
        end else if (data_read_n != 2'b11) begin
            start_read = 1'b1;
        end else if (data_write_n != 2'b11) begin
            start_write = 1'b1;
        end else if (instr_fetch_restart) begin
            start_instr = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_active <= 1'b0;
        end else if (stop_txn) begin
            instr_active <= 1'b0;
        end else if (!bus.busy) begin
            instr_active <= start_instr;
        end
    end

    assign is_instr = instr_active || start_instr;
    assign txn_len  = is_instr ? 2'd1 : data_txn_len;

    assign bus.addr        = is_instr ? {1'b0, instr_addr, 1'b0} : data_addr;
    assign bus.wdata       = data_to_write[{byte_idx, 3'b000} +: 8];
    assign bus.start_read  = start_read || start_instr;
    assign bus.start_write = start_write;
    assign bus.stop        = stop_txn;
    // Hold only inside the second byte of a halfword
    assign bus.stall       = instr_active && instr_fetch_stall && byte_idx == 2'd1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_fetch_started <= 1'b0;
            instr_fetch_stopped <= 1'b0;
            write_done          <= 1'b0;
        end else begin
            instr_fetch_started <= start_instr;
            instr_fetch_stopped <= stop_txn;
            write_done          <= bus.data_req && byte_idx == data_txn_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            byte_idx <= '0;
        end else if (start_instr || start_read || start_write) begin
            byte_idx <= '0;
        end else if (bus.data_ready || bus.data_req) begin
            if (byte_idx == txn_len) begin
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.data_ready) begin
            rd_buf[{byte_idx, 3'b000} +: 8] <= bus.rdata;
        end
    end

    assign instr_data  = {bus.rdata, rd_buf[7:0]};
    assign instr_ready = instr_active && bus.data_ready && byte_idx == 2'd1;

    assign data_ready = !instr_active &&
                        ((bus.data_ready && byte_idx == data_txn_len) || write_done);

    // Last byte comes straight from the bus, little-endian
    assign data_from_read = data_ready ?
        {bus.rdata, rd_buf[23:16],
         data_txn_len == 2'd1 ? bus.rdata : rd_buf[15:8],
         data_txn_len == 2'd0 ? bus.rdata : rd_buf[7:0]} : rd_buf;

    // Every completion falls inside a running bus transfer
    a_ready_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        (instr_ready || data_ready) |-> bus.busy && !(instr_ready && data_ready));

endmodule

//--- hw/qspi_mem_top.sv
// Fetches always target flash; DUMMY_CYCLES must match the dummy clocks of the attached devices
`timescale 1ns/1ps

module qspi_mem_top #(
    parameter int DUMMY_CYCLES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  qspi_mem_pkg::instr_addr_t instr_addr,
    input  logic                      instr_fetch_restart,
    input  logic                      instr_fetch_stall,
    output logic                      instr_fetch_started,
    output logic                      instr_fetch_stopped,
    output qspi_mem_pkg::half_t       instr_data,
    output logic                      instr_ready,
    input  qspi_mem_pkg::mem_addr_t   data_addr,
    input  qspi_mem_pkg::size_code_t  data_write_n,
    input  qspi_mem_pkg::size_code_t  data_read_n,
    input  qspi_mem_pkg::word_t       data_to_write,
    output logic                      data_ready,
    output qspi_mem_pkg::word_t       data_from_read,
    input  qspi_mem_pkg::nibble_t     spi_data_in,
    output qspi_mem_pkg::nibble_t     spi_data_out,
    output qspi_mem_pkg::nibble_t     spi_data_oe,
    output logic                      spi_clk_out,
    output logic                      spi_flash_select,
    output logic                      spi_ram_a_select,
    output logic                      spi_ram_b_select
);

    qspi_bus_if bus ();

    qspi_mem_ctrl qspi_mem_ctrl_inst (
        .clk                 (clk),
        .rstn                (rstn),
        .bus                 (bus.requester),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall),
        .instr_fetch_started (instr_fetch_started),
        .instr_fetch_stopped (instr_fetch_stopped),
        .instr_data          (instr_data),
        .instr_ready         (instr_ready),
        .data_addr           (data_addr),
        .data_write_n        (data_write_n),
        .data_read_n         (data_read_n),
        .data_to_write       (data_to_write),
        .data_ready          (data_ready),
        .data_from_read      (data_from_read)
    );

    qspi_controller #(
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) qspi_controller_inst (
        .clk              (clk),
        .rstn             (rstn),
        .bus              (bus.engine),
        .spi_data_in      (spi_data_in),
        .spi_data_out     (spi_data_out),
        .spi_data_oe      (spi_data_oe),
        .spi_clk_out      (spi_clk_out),
        .spi_flash_select (spi_flash_select),
        .spi_ram_a_select (spi_ram_a_select),
        .spi_ram_b_select (spi_ram_b_select)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock from time zero; reset is released on a falling edge after RESET_CYCLES
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

//--- testbench/qspi_device_model.sv
// Memories wrap at MEM_BYTES; region 0 is flash, 1 is RAM A, 2 is RAM B; no command checking
`timescale 1ns/1ps

module qspi_device_model #(
    parameter int DUMMY_CYCLES = 4,
    parameter int MEM_BYTES    = 4096
) (
    input  logic                  spi_clk,
    input  qspi_mem_pkg::nibble_t spi_data_out,
    input  logic                  flash_select,
    input  logic                  ram_a_select,
    input  logic                  ram_b_select,
    output qspi_mem_pkg::nibble_t spi_data_in
);

    qspi_mem_pkg::byte_t mem [0:2][0:MEM_BYTES-1];
    qspi_mem_pkg::byte_t cmd;
    qspi_mem_pkg::byte_t wbuf;
    qspi_mem_pkg::byte_t rbyte;
    logic [23:0]         addr;
    int                  rise_cnt = 0;
    int                  idx;
    int                  region;
    logic                deselected;

    assign deselected = flash_select && ram_a_select && ram_b_select;
    assign region     = !flash_select ? 0 : (!ram_a_select ? 1 : 2);

    initial spi_data_in = '0;

    // Lanes are sampled on the rising SPI edge
    always @(posedge spi_clk or posedge deselected) begin
        if (deselected) begin
            rise_cnt = 0;
        end else begin
            if (rise_cnt < 2) begin
                cmd = {cmd[3:0], spi_data_out};
            end else if (rise_cnt < 8) begin
                addr = {addr[19:0], spi_data_out};
            end else if (cmd == qspi_mem_pkg::CMD_WRITE) begin
                wbuf = {wbuf[3:0], spi_data_out};
                if (rise_cnt % 2 == 1) begin
                    mem[region][int'(addr) % MEM_BYTES] = wbuf;
                    addr = addr + 24'd1;
                end
            end
            rise_cnt = rise_cnt + 1;
        end
    end

    // Read data launched on the falling edge, high nibble first
    always @(negedge spi_clk) begin
        if (!deselected && cmd == qspi_mem_pkg::CMD_READ &&
            rise_cnt >= 8 + DUMMY_CYCLES) begin
            idx         = rise_cnt - 8 - DUMMY_CYCLES;
            rbyte       = mem[region][(int'(addr) + idx / 2) % MEM_BYTES];
            spi_data_in = (idx % 2 == 1) ? rbyte[3:0] : rbyte[7:4];
        end
    end

endmodule

//--- testbench/qspi_mem_tb.sv
// Only the low 4 KiB of each device is used; the first error ends the run
`timescale 1ns/1ps

module qspi_mem_tb;

    localparam int          DUMMY_CYCLES = 4;
    localparam int          MEM_BYTES    = 4096;
    localparam int          TIMEOUT      = 4000;
    localparam logic [24:0] RAM_A_BASE   = 25'h100_0000;
    localparam logic [24:0] RAM_B_BASE   = 25'h180_0000;

    logic clk;
    logic rstn;
    logic [22:0] instr_addr;
    logic instr_fetch_restart;
    logic instr_fetch_stall;
    logic instr_fetch_started;
    logic instr_fetch_stopped;
    logic [15:0] instr_data;
    logic instr_ready;
    logic [24:0] data_addr;
    logic [1:0] data_write_n;
    logic [1:0] data_read_n;
    logic [31:0] data_to_write;
    logic data_ready;
    logic [31:0] data_from_read;
    logic [3:0] spi_data_in;
    logic [3:0] spi_data_out;
    logic [3:0] spi_data_oe;
    logic spi_clk_out;
    logic spi_flash_select;
    logic spi_ram_a_select;
    logic spi_ram_b_select;

    logic [7:0]  shadow [0:2][0:MEM_BYTES-1];
    logic [24:0] fetch_addr;
    logic        stall_en;
    logic        result_shown = 1'b0;
    int          halves_seen;
    int          stops_seen;

    tb_clock_gen clock_gen_inst (.clk(clk), .rstn(rstn));

    qspi_mem_top #(.DUMMY_CYCLES(DUMMY_CYCLES)) qspi_mem_top_inst (.*);

    qspi_device_model #(.DUMMY_CYCLES(DUMMY_CYCLES), .MEM_BYTES(MEM_BYTES)) device (
        .spi_clk      (spi_clk_out),
        .spi_data_out (spi_data_out),
        .flash_select (spi_flash_select),
        .ram_a_select (spi_ram_a_select),
        .ram_b_select (spi_ram_b_select),
        .spi_data_in  (spi_data_in)
    );

    function automatic int region_of(input logic [24:0] addr);
        return !addr[24] ? 0 : (addr[23] ? 2 : 1);
    endfunction

    // Little-endian word from the shadow, bytes above nbytes read as zero
    function automatic logic [31:0] expected_read(input logic [24:0] addr, input int nbytes);
        logic [31:0] w;
        int r;
        w = '0;
        r = region_of(addr);
        for (int i = 0; i < nbytes; i++) begin
            w[8*i +: 8] = shadow[r][(int'(addr[11:0]) + i) % MEM_BYTES];
        end
        return w;
    endfunction

    function automatic logic [31:0] size_mask(input int nbytes);
        return (nbytes == 4) ? 32'hffff_ffff : ((32'h1 << (8 * nbytes)) - 32'h1);
    endfunction

    function automatic logic [1:0] size_code(input int nbytes);
        return (nbytes == 1) ? 2'd0 : ((nbytes == 2) ? 2'd1 : 2'd2);
    endfunction

    function automatic int random_size();
        int pick;
        pick = $urandom_range(0, 2);
        return (pick == 0) ? 1 : ((pick == 1) ? 2 : 4);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            result_shown = 1'b1;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic timeout_fail(input string what);
        result_shown = 1'b1;
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // Request levels held until data_ready, released one cycle later
    task automatic data_access(input logic [24:0] addr, input int nbytes, input logic is_write,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        data_addr     = addr;
        data_to_write = wdata;
        if (is_write) begin
            data_write_n = size_code(nbytes);
        end else begin
            data_read_n = size_code(nbytes);
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("data_ready");
        end while (!data_ready);
        rdata = data_from_read;
        @(negedge clk);
        data_read_n  = 2'b11;
        data_write_n = 2'b11;
        if (is_write) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[region_of(addr)][(int'(addr[11:0]) + i) % MEM_BYTES] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic write_word(input logic [24:0] addr, input int nbytes, input logic [31:0] wdata);
        logic [31:0] unused;
        data_access(addr, nbytes, 1'b1, wdata, unused);
    endtask

    task automatic read_and_check(input logic [24:0] addr, input int nbytes, input string msg);
        logic [31:0] got;
        data_access(addr, nbytes, 1'b0, '0, got);
        check_value(got & size_mask(nbytes), expected_read(addr, nbytes), msg);
    endtask

    task automatic start_fetch(input logic [22:0] haddr);
        @(negedge clk);
        instr_addr          = haddr;
        fetch_addr          = {1'b0, haddr, 1'b0};
        instr_fetch_restart = 1'b1;
        @(negedge clk);
        check_value({31'd0, instr_fetch_started}, 32'd1, "fetch started pulse");
        instr_fetch_restart = 1'b0;
    endtask

    task automatic wait_halves(input int count);
        int target;
        int n;
        target = halves_seen + count;
        n = 0;
        while (halves_seen < target) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT * count) timeout_fail("fetched halfwords");
        end
    endtask

    // A data read while fetching must stop the fetch first
    task automatic preempt_read(input logic [24:0] addr);
        int stops_before;
        stops_before = stops_seen;
        read_and_check(addr, 4, "read during fetch");
        check_value(stops_seen, stops_before + 1, "fetch stopped pulse count");
    endtask

    // Compare process for the fetch stream
    always @(negedge clk) begin
        if (rstn && instr_ready) begin
            check_value({16'd0, instr_data}, expected_read(fetch_addr, 2), "fetch halfword");
            // Flash drives the lanes during read data
            check_value({28'd0, spi_data_oe}, 32'd0, "output enables during fetch data");
            fetch_addr  = fetch_addr + 25'd2;
            halves_seen = halves_seen + 1;
        end
        if (rstn && instr_fetch_stopped) begin
            stops_seen = stops_seen + 1;
        end
    end

    always @(negedge clk) begin
        instr_fetch_stall = stall_en && ($urandom_range(0, 1) == 1);
    end

    // Runs that stop on an RTL assertion still end with a result line
    final begin
        if (!result_shown) begin
            $display("TEST RESULT: FAIL");
        end
    end

    initial begin
        int off;
        int n;
        instr_addr          = '0;
        instr_fetch_restart = 1'b0;
        instr_fetch_stall   = 1'b0;
        data_addr           = '0;
        data_write_n        = 2'b11;
        data_read_n         = 2'b11;
        data_to_write       = '0;
        stall_en            = 1'b0;
        halves_seen         = 0;
        stops_seen          = 0;
        fetch_addr          = '0;
        void'($urandom(32'h34079a93));
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                shadow[r][i]     = 8'($urandom);
                device.mem[r][i] = shadow[r][i];
            end
        end

        n = 0;
        while (!rstn) begin
            @(negedge clk);
            n++;
            if (n > 100) timeout_fail("reset release");
        end
        @(negedge clk);
        check_value({24'd0, spi_flash_select, spi_ram_a_select, spi_ram_b_select, spi_clk_out,
                     instr_ready, data_ready, instr_fetch_started, instr_fetch_stopped},
                    32'h0000_00e0, "state after reset");
        check_value({28'd0, spi_data_oe}, 32'd0, "output enables after reset");

        repeat (24) begin
            off = $urandom_range(0, MEM_BYTES - 5);
            write_word(RAM_A_BASE + 25'(off), random_size(), $urandom);
            read_and_check(RAM_A_BASE + 25'(off), random_size(), "RAM A read back");
        end

        repeat (8) begin
            off = $urandom_range(0, MEM_BYTES - 5);
            write_word(RAM_B_BASE + 25'(off), 4, $urandom);
            read_and_check(RAM_A_BASE + 25'(off), 4, "RAM A after RAM B write");
            read_and_check(RAM_B_BASE + 25'(off), random_size(), "RAM B read");
            read_and_check(25'($urandom_range(0, MEM_BYTES - 5)), random_size(), "flash read");
        end

        stall_en = 1'b1;
        start_fetch(23'($urandom_range(0, MEM_BYTES / 2 - 1)));
        wait_halves(40);
        preempt_read(25'($urandom_range(0, MEM_BYTES - 5)));
        start_fetch(23'($urandom_range(0, MEM_BYTES / 2 - 1)));
        wait_halves(20);
        preempt_read(RAM_A_BASE + 25'($urandom_range(0, MEM_BYTES - 5)));
        stall_en = 1'b0;

        result_shown = 1'b1;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sources.f
hw/qspi_mem_pkg.sv
hw/qspi_bus_if.sv
hw/qspi_controller.sv
hw/qspi_mem_ctrl.sv
hw/qspi_mem_top.sv
testbench/tb_clock_gen.sv
testbench/qspi_device_model.sv
testbench/qspi_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module qspi_mem_tb \
    -o qspi_mem_sim

./obj_dir/qspi_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
